/* common/ooo_pkg.sv */
package ooo_pkg;

    // ------------------------------------------------------------------
    // core-wide widths
    localparam int WORD_W    = 32;
    localparam int TAG_W     = 5;
    // external beat plus the cluster write-back beat
    localparam int CDB_COUNT = 2;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  rob_id_t;

    // value only meaningful once ready is set
    typedef struct packed {
        logic    ready;
        rob_id_t tag;
        word_t   value;
    } operand_t;

    // one common data bus beat
    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   value;
    } cdb_t;

endpackage

/* common/mdu_pkg.sv */
package mdu_pkg;

    import ooo_pkg::*;

    // ------------------------------------------------------------------
    // issue queue sizing
    localparam int IQ_DEPTH       = 4;
    localparam int DISPATCH_WIDTH = 2;
    localparam int IQ_PTR_W       = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W       = $clog2(IQ_DEPTH + 1);

    // divider step counter, one quotient bit per step
    localparam int DIV_CNT_W      = $clog2(WORD_W);

    typedef enum logic [1:0] {
        MDU_MUL   = 2'd0,
        MDU_MULHU = 2'd1,
        MDU_DIVU  = 2'd2,
        MDU_REMU  = 2'd3
    } mdu_op_t;

    typedef struct packed {
        logic     valid;
        mdu_op_t  op;
        rob_id_t  tag;
        operand_t src_a;
        operand_t src_b;
    } mdu_instr_t;

    typedef struct packed {
        mdu_op_t op;
        rob_id_t tag;
        word_t   src_a;
        word_t   src_b;
    } mdu_req_t;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   value;
    } mdu_res_t;

endpackage

/* mdu_iq/iq_entry.sv */
`timescale 1ns/1ps

module iq_entry import ooo_pkg::*, mdu_pkg::*; (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  logic                     init_i,
    input  mdu_instr_t               instr_i,
    input  cdb_t [CDB_COUNT-1:0]     cdb_i,
    input  logic                     release_i,
    output mdu_instr_t               instr_o,
    output logic                     ready_o
);

    mdu_instr_t entry_q;
    mdu_instr_t entry_d;

    // capture a waiting operand from any matching beat
    function automatic operand_t snoop(operand_t opnd, cdb_t [CDB_COUNT-1:0] cdb);
        operand_t res;
        res = opnd;
        for (int k = 0; k < CDB_COUNT; k++) begin
            if (!opnd.ready && cdb[k].valid && cdb[k].tag == opnd.tag) begin
                res.ready = 1'b1;
                res.value = cdb[k].value;
            end
        end
        return res;
    endfunction

    always_comb begin
        entry_d = entry_q;
        if (release_i) begin
            entry_d.valid = 1'b0;
        end
        // new instruction is checked against the bus in the same cycle
        if (init_i) begin
            entry_d = instr_i;
        end
        entry_d.src_a = snoop(entry_d.src_a, cdb_i);
        entry_d.src_b = snoop(entry_d.src_b, cdb_i);
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            entry_q.valid <= 1'b0;
        end else begin
            entry_q <= entry_d;
        end
    end

    assign instr_o = entry_q;
    assign ready_o = entry_q.valid && entry_q.src_a.ready && entry_q.src_b.ready;

endmodule

/* mdu_iq/mdu_iq.sv */
`timescale 1ns/1ps

module mdu_iq import ooo_pkg::*, mdu_pkg::*; (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              flush_i,
    input  mdu_instr_t [DISPATCH_WIDTH-1:0]   dispatch_i,
    output logic                              dispatch_ready_o,
    input  cdb_t       [CDB_COUNT-1:0]        cdb_i,
    output mdu_req_t                          mul_req_o,
    output mdu_req_t                          div_req_o,
    output logic                              mul_valid_o,
    output logic                              div_valid_o,
    input  logic                              mul_ready_i,
    input  logic                              div_ready_i
);

    logic [IQ_PTR_W-1:0]       head_q;
    logic [IQ_PTR_W-1:0]       tail_q;
    logic [IQ_PTR_W-1:0]       slot1_pos;
    logic [IQ_CNT_W-1:0]       free_q;
    logic [IQ_CNT_W-1:0]       free_d;
    logic [DISPATCH_WIDTH-1:0] disp_ok;
    logic [1:0]                disp_cnt;

    mdu_instr_t [IQ_DEPTH-1:0] entry_instr;
    mdu_instr_t [IQ_DEPTH-1:0] entry_wdata;
    logic       [IQ_DEPTH-1:0] entry_ready;
    logic       [IQ_DEPTH-1:0] entry_init;
    logic       [IQ_DEPTH-1:0] entry_release;

    mdu_instr_t head_instr;
    logic       head_ready;
    logic       head_is_div;
    logic       issue;
    mdu_req_t   head_req;

    // ------------------------------------------------------------------
    // dispatch at the tail, slot 0 first
    assign disp_ok[0] = dispatch_i[0].valid && dispatch_ready_o;
    assign disp_ok[1] = dispatch_i[1].valid && dispatch_ready_o;
    assign disp_cnt   = 2'(disp_ok[0]) + 2'(disp_ok[1]);
    assign slot1_pos  = tail_q + IQ_PTR_W'(disp_ok[0]);

    assign free_d = free_q - IQ_CNT_W'(disp_cnt) + IQ_CNT_W'(issue);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q           <= '0;
            tail_q           <= '0;
            free_q           <= IQ_CNT_W'(IQ_DEPTH);
            dispatch_ready_o <= 1'b1;
        end else begin
            head_q           <= head_q + IQ_PTR_W'(issue);
            tail_q           <= tail_q + IQ_PTR_W'(disp_cnt);
            free_q           <= free_d;
            // room for a full dispatch group
            dispatch_ready_o <= free_d >= IQ_CNT_W'(DISPATCH_WIDTH);
        end
    end

    // ------------------------------------------------------------------
    // queue slots
    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_entry
        assign entry_init[i] = (disp_ok[0] && tail_q == IQ_PTR_W'(i))
                            || (disp_ok[1] && slot1_pos == IQ_PTR_W'(i));
        assign entry_wdata[i] = (disp_ok[1] && slot1_pos == IQ_PTR_W'(i))
                              ? dispatch_i[1] : dispatch_i[0];
        assign entry_release[i] = issue && head_q == IQ_PTR_W'(i);

        iq_entry u_entry (
            .clk       (clk),
            .reset_i   (reset_i),
            .flush_i   (flush_i),
            .init_i    (entry_init[i]),
            .instr_i   (entry_wdata[i]),
            .cdb_i     (cdb_i),
            .release_i (entry_release[i]),
            .instr_o   (entry_instr[i]),
            .ready_o   (entry_ready[i])
        );
    end

    // ------------------------------------------------------------------
    // in-order issue from the head, steered by op
    assign head_instr  = entry_instr[head_q];
    assign head_ready  = entry_ready[head_q];
    assign head_is_div = head_instr.op inside {MDU_DIVU, MDU_REMU};

    assign mul_valid_o = head_ready && !head_is_div;
    assign div_valid_o = head_ready && head_is_div;
    assign issue       = (mul_valid_o && mul_ready_i) || (div_valid_o && div_ready_i);

    assign head_req = '{
        op:    head_instr.op,
        tag:   head_instr.tag,
        src_a: head_instr.src_a.value,
        src_b: head_instr.src_b.value
    };

    assign mul_req_o = head_req;
    assign div_req_o = head_req;

endmodule

/* mdu/mdu_mul.sv */
`timescale 1ns/1ps

module mdu_mul import ooo_pkg::*, mdu_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    input  mdu_req_t req_i,
    input  logic     valid_i,
    output logic     ready_o,
    output mdu_res_t res_o,
    input  logic     grant_i
);

    logic                         advance;
    logic                         s1_valid_q;
    mdu_op_t                      s1_op_q;
    rob_id_t                      s1_tag_q;
    // partial products on the low and high half of operand b
    logic [WORD_W+WORD_W/2-1:0]   s1_pp_lo_q;
    logic [WORD_W+WORD_W/2-1:0]   s1_pp_hi_q;
    logic [2*WORD_W-1:0]          product;
    mdu_res_t                     res_q;

    // whole pipe moves only when the output slot frees up
    assign advance = !res_q.valid || grant_i;
    assign ready_o = advance;

    assign product = {{(WORD_W/2){1'b0}}, s1_pp_lo_q} + {s1_pp_hi_q, {(WORD_W/2){1'b0}}};

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            s1_valid_q  <= 1'b0;
            res_q.valid <= 1'b0;
        end else if (advance) begin
            s1_valid_q  <= valid_i;
            s1_op_q     <= req_i.op;
            s1_tag_q    <= req_i.tag;
            s1_pp_lo_q  <= req_i.src_a * req_i.src_b[WORD_W/2-1:0];
            s1_pp_hi_q  <= req_i.src_a * req_i.src_b[WORD_W-1:WORD_W/2];
            res_q.valid <= s1_valid_q;
            res_q.tag   <= s1_tag_q;
            res_q.value <= (s1_op_q == MDU_MULHU) ? product[2*WORD_W-1:WORD_W]
                                                  : product[WORD_W-1:0];
        end
    end

    assign res_o = res_q;

endmodule

/* mdu/mdu_div.sv */
`timescale 1ns/1ps

module mdu_div import ooo_pkg::*, mdu_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    input  mdu_req_t req_i,
    input  logic     valid_i,
    output logic     ready_o,
    output mdu_res_t res_o,
    input  logic     grant_i
);

    logic                 busy_q;
    logic                 done_q;
    logic [DIV_CNT_W-1:0] cnt_q;
    mdu_op_t              op_q;
    rob_id_t              tag_q;
    word_t                dvs_q;
    // partial remainder and dividend/quotient shift register
    word_t                rem_q;
    word_t                quo_q;
    logic [WORD_W:0]      shifted;
    logic [WORD_W:0]      diff;
    logic                 accept;

    assign ready_o = !busy_q && !done_q;
    assign accept  = valid_i && ready_o;

    // ------------------------------------------------------------------
    // restoring step
    // with a zero divisor every trial succeeds, so the quotient fills
    // with ones and the dividend ends up in the remainder
    assign shifted = {rem_q, quo_q[WORD_W-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == '1) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end else if (grant_i) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= req_i.op;
            tag_q <= req_i.tag;
            dvs_q <= req_i.src_b;
            quo_q <= req_i.src_a;
            rem_q <= '0;
        end else if (busy_q) begin
            if (!diff[WORD_W]) begin
                rem_q <= diff[WORD_W-1:0];
                quo_q <= {quo_q[WORD_W-2:0], 1'b1};
            end else begin
                rem_q <= shifted[WORD_W-1:0];
                quo_q <= {quo_q[WORD_W-2:0], 1'b0};
            end
        end
    end

    assign res_o = '{
        valid: done_q,
        tag:   tag_q,
        value: (op_q == MDU_REMU) ? rem_q : quo_q
    };

endmodule

/* src/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter import mdu_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    input  mdu_res_t mul_res_i,
    input  mdu_res_t div_res_i,
    output logic     mul_grant_o,
    output logic     div_grant_o,
    output mdu_res_t wb_o,
    input  logic     wb_ready_i
);

    // 1 when the divider won the last granted beat
    logic last_div_q;
    // stalled beat keeps its source until taken
    logic lock_q;
    logic lock_sel_q;
    logic pick_div;
    logic sel_div;
    logic sent;

    assign pick_div = div_res_i.valid && (!mul_res_i.valid || !last_div_q);
    assign sel_div  = lock_q ? lock_sel_q : pick_div;

    assign wb_o = sel_div ? div_res_i : mul_res_i;
    assign sent = wb_o.valid && wb_ready_i;

    assign mul_grant_o = sent && !sel_div;
    assign div_grant_o = sent && sel_div;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            last_div_q <= 1'b0;
            lock_q     <= 1'b0;
            lock_sel_q <= 1'b0;
        end else begin
            lock_q     <= wb_o.valid && !wb_ready_i;
            lock_sel_q <= sel_div;
            if (sent) begin
                last_div_q <= sel_div;
            end
        end
    end

endmodule

/* src/mdu_cluster.sv */
`timescale 1ns/1ps

module mdu_cluster import ooo_pkg::*, mdu_pkg::*; (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            flush_i,
    input  mdu_instr_t [DISPATCH_WIDTH-1:0] dispatch_i,
    output logic                            dispatch_ready_o,
    input  cdb_t                            cdb_ext_i,
    output mdu_res_t                        wb_o,
    input  logic                            wb_ready_i
);

    mdu_req_t             mul_req;
    mdu_req_t             div_req;
    logic                 mul_valid;
    logic                 div_valid;
    logic                 mul_ready;
    logic                 div_ready;
    mdu_res_t             mul_res;
    mdu_res_t             div_res;
    logic                 mul_grant;
    logic                 div_grant;
    cdb_t [CDB_COUNT-1:0] cdb;

    // snooped beats: outside unit, then our own sent result
    assign cdb[0] = cdb_ext_i;
    assign cdb[1] = '{valid: wb_o.valid && wb_ready_i, tag: wb_o.tag, value: wb_o.value};

    mdu_iq u_iq (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .cdb_i            (cdb),
        .mul_req_o        (mul_req),
        .div_req_o        (div_req),
        .mul_valid_o      (mul_valid),
        .div_valid_o      (div_valid),
        .mul_ready_i      (mul_ready),
        .div_ready_i      (div_ready)
    );

    mdu_mul u_mul (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .req_i   (mul_req),
        .valid_i (mul_valid),
        .ready_o (mul_ready),
        .res_o   (mul_res),
        .grant_i (mul_grant)
    );

    mdu_div u_div (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .req_i   (div_req),
        .valid_i (div_valid),
        .ready_o (div_ready),
        .res_o   (div_res),
        .grant_i (div_grant)
    );

    wb_arbiter u_arb (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .mul_res_i   (mul_res),
        .div_res_i   (div_res),
        .mul_grant_o (mul_grant),
        .div_grant_o (div_grant),
        .wb_o        (wb_o),
        .wb_ready_i  (wb_ready_i)
    );

endmodule

/* bench/mdu_cluster_assert.sv */
`timescale 1ns/1ps

module mdu_cluster_assert import ooo_pkg::*, mdu_pkg::*; (
    input logic                            clk,
    input logic                            reset_i,
    input logic                            flush_i,
    input mdu_instr_t [DISPATCH_WIDTH-1:0] dispatch_i,
    input logic                            dispatch_ready_o,
    input mdu_res_t                        wb_o,
    input logic                            wb_ready_i
);

    // a stalled beat must not change
    wb_hold: assert property (@(posedge clk) disable iff (reset_i || flush_i)
        wb_o.valid && !wb_ready_i |=> $stable(wb_o))
        else $error("wb_o changed while stalled");

    no_dispatch_when_full: assert property (@(posedge clk) disable iff (reset_i)
        !dispatch_ready_o |-> !(dispatch_i[0].valid || dispatch_i[1].valid))
        else $error("dispatch while dispatch_ready_o low");

    wb_idle_after_reset: assert property (@(posedge clk)
        reset_i |=> !wb_o.valid)
        else $error("wb_o valid after reset");

endmodule

bind mdu_cluster mdu_cluster_assert u_assert (.*);

/* bench/mdu_cluster_tb.sv */
`timescale 1ns/1ps

module mdu_cluster_tb import ooo_pkg::*, mdu_pkg::*; ();

    localparam int EXT_TAG0 = 24;
    localparam int WAIT_MAX = 3000;

    logic                            clk;
    logic                            reset_i;
    logic                            flush_i;
    mdu_instr_t [DISPATCH_WIDTH-1:0] dispatch_i;
    logic                            dispatch_ready_o;
    cdb_t                            cdb_ext_i;
    mdu_res_t                        wb_o;
    logic                            wb_ready_i;

    // ------------------------------------------------------------------
    // scoreboard state, indexed by tag
    logic  pending [32];
    logic  is_div [32];
    logic  ext_sent [32];
    word_t exp_val [32];
    int    dep_a [32];
    int    dep_b [32];
    int    mul_order [$];
    int    div_order [$];
    int    outstanding;
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    next_tag;
    int    next_ext;
    logic  bp_en;
    int    bp_left;
    logic  saw_full;

    mdu_cluster dut0 (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .cdb_ext_i        (cdb_ext_i),
        .wb_o             (wb_o),
        .wb_ready_i       (wb_ready_i)
    );

    always #5 clk = ~clk;

    // expected result by the unsigned rules
    function automatic word_t ref_result(mdu_op_t op, word_t a, word_t b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        case (op)
            MDU_MUL:   return prod[31:0];
            MDU_MULHU: return prod[63:32];
            MDU_DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
            default:   return (b == 0) ? a : a % b;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic abort_on_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    // ------------------------------------------------------------------
    // monitor on sent write-back beats
    always @(posedge clk) begin
        int t;
        int front;
        if (!reset_i && wb_o.valid && wb_ready_i) begin
            t = wb_o.tag;
            if (!pending[t]) begin
                errors++;
                $display("result for tag %0d was not expected", t);
            end else begin
                check_value("wb_o.value", wb_o.value, exp_val[t]);
                if ((dep_a[t] >= 0 && !ext_sent[dep_a[t]])
                    || (dep_b[t] >= 0 && !ext_sent[dep_b[t]])) begin
                    errors++;
                    $display("tag %0d completed before its operand was driven", t);
                end
                front = is_div[t] ? div_order.pop_front() : mul_order.pop_front();
                if (front != t) begin
                    errors++;
                    $display("tag %0d left its unit out of order", t);
                end
                pending[t] = 1'b0;
                outstanding--;
            end
        end
    end

    // random write-back stalls
    always @(posedge clk) begin
        #1;
        if (bp_en) begin
            if (bp_left == 0) begin
                wb_ready_i = ~wb_ready_i;
                bp_left    = 1 + $urandom % 8;
            end else begin
                bp_left--;
            end
            if (!dispatch_ready_o) begin
                saw_full = 1'b1;
            end
        end else begin
            wb_ready_i = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // ROB side helpers
    function automatic operand_t ready_opnd(word_t v);
        operand_t o;
        o.ready = 1'b1;
        o.tag   = '0;
        o.value = v;
        return o;
    endfunction

    function automatic operand_t wait_opnd(int t);
        operand_t o;
        o.ready = 1'b0;
        o.tag   = rob_id_t'(t);
        o.value = '0;
        return o;
    endfunction

    function automatic word_t rand_word();
        case ($urandom % 4)
            0:       return $urandom % 16;
            1:       return 32'hffff_ffff - $urandom % 4;
            default: return $urandom;
        endcase
    endfunction

    function automatic int alloc_tag();
        for (int i = 0; i < EXT_TAG0; i++) begin
            next_tag = (next_tag + 1) % EXT_TAG0;
            if (!pending[next_tag]) begin
                return next_tag;
            end
        end
        return -1;
    endfunction

    function automatic int alloc_ext();
        next_ext = EXT_TAG0 + (next_ext + 1 - EXT_TAG0) % (32 - EXT_TAG0);
        ext_sent[next_ext] = 1'b0;
        return next_ext;
    endfunction

    // builds one instruction and enters it into the scoreboard
    task automatic make_instr(output mdu_instr_t ins, input mdu_op_t op,
                              input operand_t a, input operand_t b, input word_t exp,
                              input int da, input int db);
        int t;
        t = alloc_tag();
        if (t < 0) begin
            abort_on_timeout("a free tag");
        end
        ins.valid   = 1'b1;
        ins.op      = op;
        ins.tag     = rob_id_t'(t);
        ins.src_a   = a;
        ins.src_b   = b;
        pending[t]  = 1'b1;
        exp_val[t]  = exp;
        dep_a[t]    = da;
        dep_b[t]    = db;
        is_div[t]   = op inside {MDU_DIVU, MDU_REMU};
        if (is_div[t]) begin
            div_order.push_back(t);
        end else begin
            mul_order.push_back(t);
        end
        outstanding++;
    endtask

    task automatic random_instr(output mdu_instr_t ins, input mdu_op_t op);
        word_t a;
        word_t b;
        a = rand_word();
        b = rand_word();
        make_instr(ins, op, ready_opnd(a), ready_opnd(b), ref_result(op, a, b), -1, -1);
    endtask

    task automatic dispatch_group(input mdu_instr_t i0, input mdu_instr_t i1);
        int n;
        n = 0;
        while (!dispatch_ready_o) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_MAX) begin
                abort_on_timeout("dispatch_ready_o");
            end
        end
        dispatch_i[0] = i0;
        dispatch_i[1] = i1;
        @(posedge clk);
        #1;
        dispatch_i = '0;
    endtask

    task automatic drive_ext(int t, word_t v);
        ext_sent[t]     = 1'b1;
        cdb_ext_i.valid = 1'b1;
        cdb_ext_i.tag   = rob_id_t'(t);
        cdb_ext_i.value = v;
        @(posedge clk);
        #1;
        cdb_ext_i = '0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (outstanding != 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_MAX) begin
                abort_on_timeout("outstanding results");
            end
        end
    endtask

    task automatic random_groups(int count, int div_bias);
        mdu_instr_t i0;
        mdu_instr_t i1;
        for (int g = 0; g < count; g++) begin
            random_instr(i0, ($urandom % 4 < div_bias) ? mdu_op_t'(2 + $urandom % 2)
                                                       : mdu_op_t'($urandom % 4));
            i1 = '0;
            if ($urandom % 2) begin
                random_instr(i1, mdu_op_t'($urandom % 4));
            end
            dispatch_group(i0, i1);
        end
    endtask

    task automatic finish_test(string name, int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    initial begin
        mdu_instr_t i0;
        mdu_instr_t i1;
        word_t      a;
        word_t      b;
        word_t      c;
        int         e0;
        int         e1;
        int         err0;

        void'($urandom(32'hb877f525));
        clk = 0;
        reset_i = 1;
        flush_i = 0;
        dispatch_i = '0;
        cdb_ext_i = '0;
        wb_ready_i = 1;
        bp_en = 0;
        bp_left = 0;
        saw_full = 0;
        outstanding = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        next_tag = 0;
        next_ext = EXT_TAG0;
        for (int t = 0; t < 32; t++) begin
            pending[t] = 0;
            ext_sent[t] = 0;
        end
        repeat (8) @(posedge clk);
        #1;
        reset_i = 0;

        err0 = errors;
        random_groups(40, 0);
        drain();
        finish_test("ready operands", err0);

        err0 = errors;
        for (int r = 0; r < 6; r++) begin
            a  = rand_word();
            b  = rand_word();
            e0 = alloc_ext();
            e1 = alloc_ext();
            make_instr(i0, MDU_MUL, wait_opnd(e0), ready_opnd(b),
                       ref_result(MDU_MUL, a, b), e0, -1);
            make_instr(i1, mdu_op_t'($urandom % 4), wait_opnd(e1), wait_opnd(e0), '0, e1, e0);
            exp_val[i1.tag] = ref_result(i1.op, b, a);
            dispatch_group(i0, i1);
            repeat (6) @(posedge clk);
            #1;
            drive_ext(e0, a);
            drive_ext(e1, b);
            // dependent multiply chain through our own write-back
            c = rand_word();
            random_instr(i0, MDU_MUL);
            a = i0.src_a.value;
            b = i0.src_b.value;
            make_instr(i1, MDU_MUL, wait_opnd(i0.tag), ready_opnd(c),
                       ref_result(MDU_MUL, ref_result(MDU_MUL, a, b), c), -1, -1);
            dispatch_group(i0, i1);
        end
        drain();
        finish_test("waiting operands", err0);

        err0 = errors;
        a = rand_word();
        make_instr(i0, MDU_DIVU, ready_opnd(a), ready_opnd(0), 32'hffff_ffff, -1, -1);
        make_instr(i1, MDU_REMU, ready_opnd(a), ready_opnd(0), a, -1, -1);
        dispatch_group(i0, i1);
        drain();
        finish_test("divide by zero", err0);

        err0 = errors;
        bp_en = 1;
        random_groups(30, 2);
        drain();
        bp_en = 0;
        if (!saw_full) begin
            errors++;
            $display("dispatch_ready_o never dropped behind the stalled divider");
        end
        finish_test("back-pressure and ordering", err0);

        err0 = errors;
        random_instr(i0, MDU_DIVU);
        e0 = alloc_ext();
        make_instr(i1, MDU_MUL, wait_opnd(e0), ready_opnd(1), '0, e0, -1);
        dispatch_group(i0, i1);
        // two more behind the blocked head fill the queue
        random_instr(i0, MDU_MUL);
        random_instr(i1, MDU_MUL);
        dispatch_group(i0, i1);
        repeat (3) @(posedge clk);
        #1;
        check_value("dispatch_ready_o", dispatch_ready_o, 0);
        flush_i = 1;
        @(posedge clk);
        #1;
        flush_i = 0;
        for (int t = 0; t < 32; t++) begin
            pending[t] = 0;
        end
        mul_order.delete();
        div_order.delete();
        outstanding = 0;
        // longer than one divide, so a surviving divider would show
        for (int k = 0; k < 40; k++) begin
            check_value("dispatch_ready_o", dispatch_ready_o, 1);
            check_value("wb_o.valid", wb_o.valid, 0);
            @(posedge clk);
            #1;
        end
        random_groups(8, 1);
        drain();
        finish_test("flush", err0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
common/ooo_pkg.sv
common/mdu_pkg.sv
mdu_iq/iq_entry.sv
mdu_iq/mdu_iq.sv
mdu/mdu_mul.sv
mdu/mdu_div.sv
src/wb_arbiter.sv
src/mdu_cluster.sv
bench/mdu_cluster_assert.sv
bench/mdu_cluster_tb.sv

/* Bender.yml */
package:
  name: mdu_cluster

sources:
  - common/ooo_pkg.sv
  - common/mdu_pkg.sv
  - mdu_iq/iq_entry.sv
  - mdu_iq/mdu_iq.sv
  - mdu/mdu_mul.sv
  - mdu/mdu_div.sv
  - src/wb_arbiter.sv
  - src/mdu_cluster.sv
  - target: test
    files:
      - bench/mdu_cluster_assert.sv
      - bench/mdu_cluster_tb.sv
